/* tb.f */
source/rvv_uop_pkg.sv
source/rvv_vrf_pkg.sv
source/rvv_read_alloc.sv
source/rvv_vrf.sv
source/rvv_uop_stage.sv
source/rvv_dispatch_operand.sv
source/rvv_dispatch_top.sv
tests/tb_clock_gen.sv
tests/rvv_dispatch_assertions.sv
tests/tb_rvv_dispatch.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the dispatch testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module tb_rvv_dispatch -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

output=$(./obj_dir/sim_tb +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1

/* tests/tb_rvv_dispatch.sv */
`timescale 1ns/1ps

module tb_rvv_dispatch;

  localparam int NUM_CLASS       = 7;
  localparam int NUM_STALL_PAIRS = 40;
  localparam int NUM_RANDOM      = 300;
  localparam int TOTAL_PAIRS     = 2 * NUM_CLASS + NUM_CLASS * NUM_CLASS
                                 + NUM_STALL_PAIRS + NUM_RANDOM;
  localparam int CYCLES_PER_PAIR = 20;   // two accepts each behind a stall stretch
  localparam int MAX_CYCLES      = TOTAL_PAIRS * CYCLES_PER_PAIR
                                 + 2 * rvv_vrf_pkg::NUM_VREG + 100;

  typedef struct packed {
    rvv_uop_pkg::uop_t     uop;
    rvv_vrf_pkg::uop_opn_t opn;
  } expect_t;

  logic                         clk;
  logic                         rst;
  logic [1:0]                   in_valid;
  rvv_uop_pkg::uop_t [1:0]      in_uop;
  rvv_vrf_pkg::vrf_wr_t         vrf_wr;
  logic                         out_ready;
  logic [1:0]                   in_ready;
  logic [1:0]                   out_valid;
  rvv_uop_pkg::uop_t [1:0]      out_uop;
  rvv_vrf_pkg::uop_opn_t [1:0]  out_opn;

  logic [rvv_vrf_pkg::VLEN-1:0] shadow [rvv_vrf_pkg::NUM_VREG];   // mirrors the VRF
  expect_t                      expect_q [$];
  string                        test_name = "reset";
  int                           error_count = 0;
  int                           check_count = 0;
  int                           cycle_count = 0;
  int                           stim_seed = 62;
  int                           ready_seed = 62;
  int                           stretch = 0;
  logic                         stall_mode = 1'b0;
  logic [3:0]                   next_id = '0;

  tb_clock_gen u_clock_gen (
    .clk (clk),
    .rst (rst)
  );

  rvv_dispatch_top UUT (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_uop    (in_uop),
    .vrf_wr    (vrf_wr),
    .out_ready (out_ready),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_uop   (out_uop),
    .out_opn   (out_opn)
  );

  // ************************************************************
  // reference model
  // ************************************************************
  function automatic logic [2:0] class_uses(rvv_uop_pkg::uop_class_e c);   // {vd, vs2, vs1}
    logic [2:0] u;
    u[2] = c inside {rvv_uop_pkg::VXX, rvv_uop_pkg::VVX, rvv_uop_pkg::VVV};
    u[1] = c inside {rvv_uop_pkg::XVX, rvv_uop_pkg::XVV, rvv_uop_pkg::VVX, rvv_uop_pkg::VVV};
    u[0] = c inside {rvv_uop_pkg::XXV, rvv_uop_pkg::XVV, rvv_uop_pkg::VVV};
    return u;
  endfunction

  function automatic int read_count(rvv_uop_pkg::uop_class_e c);
    logic [2:0] u;
    u = class_uses(c);
    return int'(u[0]) + int'(u[1]) + int'(u[2]);
  endfunction

  function automatic rvv_vrf_pkg::uop_opn_t expected_operands(rvv_uop_pkg::uop_t uop);
    rvv_vrf_pkg::uop_opn_t opn;
    logic [2:0]            u;
    u      = class_uses(uop.uop_class);
    opn    = '0;
    opn.v0 = shadow[0];
    if (u[2]) begin
      opn.vd = shadow[uop.vd_index];
    end
    if (u[1]) begin
      opn.vs2 = shadow[uop.vs2_index];
    end
    if (u[0]) begin
      opn.vs1 = shadow[uop.vs1_index];
    end
    return opn;
  endfunction

  task automatic check_value(input string what, input logic [255:0] expected,
                             input logic [255:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  // ************************************************************
  // stimulus helpers called on a rising edge
  // ************************************************************
  task automatic make_uop(input int cls, output rvv_uop_pkg::uop_t uop);
    logic [31:0] r;
    r             = $random(stim_seed);
    uop.uop_class = rvv_uop_pkg::uop_class_e'(cls[2:0]);
    uop.vop       = rvv_uop_pkg::vop_e'(r[31:28] % 4'd6);
    uop.vd_index  = r[4:0];
    uop.vs2_index = r[9:5];
    uop.vs1_index = r[14:10];
    uop.uop_id    = next_id;
    next_id       = next_id + 4'd1;
  endtask

  task automatic send_pair(input rvv_uop_pkg::uop_t a, input rvv_uop_pkg::uop_t b,
                           input logic two);
    in_valid <= {two, 1'b1};
    in_uop   <= {b, a};
    @(posedge clk);
    while (!in_ready[0]) @(posedge clk);
    if (two && !in_ready[1]) begin   // b did not fit and goes again alone
      in_valid <= 2'b01;
      in_uop   <= {b, b};
      @(posedge clk);
      while (!in_ready[0]) @(posedge clk);
    end
    in_valid <= '0;
  endtask

  task automatic fill_registers();
    logic [31:0] lo;
    logic [31:0] hi;
    for (int i = 0; i < rvv_vrf_pkg::NUM_VREG; i++) begin
      lo = $random(stim_seed);
      hi = $random(stim_seed);
      vrf_wr.valid <= 1'b1;
      vrf_wr.index <= i[4:0];
      vrf_wr.data  <= {hi, lo};
      @(posedge clk);
    end
    vrf_wr <= '0;
  endtask

  // ************************************************************
  // comparison against the queue of accepted uops
  // ************************************************************
  always @(posedge clk) begin : compare_outputs
    logic    ready0;
    logic    fits;
    expect_t item;
    if (!rst) begin
      ready0 = (expect_q.size() == 0) | out_ready;   // held uops are the queued ones
      fits   = (read_count(in_uop[0].uop_class) + read_count(in_uop[1].uop_class)) <= 4;
      check_value("in_ready", 256'({ready0 & fits, ready0}), 256'(in_ready));
      if ((|out_valid) && out_ready) begin
        for (int k = 0; k < 2; k++) begin
          if (out_valid[k]) begin
            if (expect_q.size() == 0) begin
              error_count++;
              $display("slot %0d left the stage with no accepted uop waiting for it", k);
            end else begin
              item = expect_q.pop_front();
              check_value("uop", 256'(item.uop), 256'(out_uop[k]));
              check_value("v0", 256'(item.opn.v0), 256'(out_opn[k].v0));
              check_value("vs1", 256'(item.opn.vs1), 256'(out_opn[k].vs1));
              check_value("vs2", 256'(item.opn.vs2), 256'(out_opn[k].vs2));
              check_value("vd", 256'(item.opn.vd), 256'(out_opn[k].vd));
            end
          end
        end
      end
      for (int k = 0; k < 2; k++) begin
        if (in_valid[k] && in_ready[k]) begin
          item.uop = in_uop[k];
          item.opn = expected_operands(in_uop[k]);   // VRF as it was before this edge
          expect_q.push_back(item);
        end
      end
    end
    if (vrf_wr.valid) begin
      shadow[vrf_wr.index] = vrf_wr.data;
    end
  end

  always @(posedge clk) begin
    if (!stall_mode) begin
      out_ready <= 1'b1;
    end else if (stretch == 0) begin
      out_ready <= ~out_ready;
      stretch = $unsigned($random(ready_seed)) % 6;
    end else begin
      stretch = stretch - 1;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    logic [31:0]       r;
    rvv_uop_pkg::uop_t a;
    rvv_uop_pkg::uop_t b;
    int                total;
    in_valid  = '0;
    in_uop    = '0;
    vrf_wr    = '0;
    out_ready = 1'b1;
    @(posedge clk);
    while (rst) @(posedge clk);
    test_name <= "preload";
    fill_registers();
    test_name <= "every_class";
    for (int c = 0; c < NUM_CLASS; c++) begin
      make_uop(c, a);
      send_pair(a, a, 1'b0);
    end
    for (int pass = 0; pass < 2; pass++) begin   // fitting pairs first and split ones after
      if (pass == 0) begin
        test_name <= "pairs_fit";
      end else begin
        test_name <= "pairs_split";
      end
      for (int c0 = 0; c0 < NUM_CLASS; c0++) begin
        for (int c1 = 0; c1 < NUM_CLASS; c1++) begin
          make_uop(c0, a);
          make_uop(c1, b);
          if (((read_count(a.uop_class) + read_count(b.uop_class)) > 4) == (pass == 1)) begin
            send_pair(a, b, 1'b1);
          end
        end
      end
    end
    test_name  <= "back_pressure";
    stall_mode <= 1'b1;
    for (int i = 0; i < NUM_STALL_PAIRS; i++) begin
      r = $random(stim_seed);
      make_uop(int'(r[7:0]) % NUM_CLASS, a);
      make_uop(int'(r[15:8]) % NUM_CLASS, b);
      send_pair(a, b, 1'b1);
    end
    stall_mode <= 1'b0;
    test_name  <= "register_update";
    fill_registers();   // v0 included
    for (int c = 0; c < NUM_CLASS; c++) begin
      make_uop(c, a);
      send_pair(a, a, 1'b0);
    end
    test_name  <= "random_mix";
    stall_mode <= 1'b1;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      r = $random(stim_seed);
      make_uop(int'(r[7:0]) % NUM_CLASS, a);
      make_uop(int'(r[15:8]) % NUM_CLASS, b);
      send_pair(a, b, r[16]);
    end
    stall_mode <= 1'b0;
    while (expect_q.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
    total = error_count + int'(UUT.u_dispatch_assertions.fail_count);
    $display("errors: %0d failed checks, %0d assertion failures, %0d checks run",
             error_count, UUT.u_dispatch_assertions.fail_count, check_count);
    if (total == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* tests/rvv_dispatch_assertions.sv */
`timescale 1ns/1ps

module rvv_dispatch_assertions (
  input logic                        clk,
  input logic                        rst,
  input logic [1:0]                  in_ready,
  input logic [1:0]                  out_valid,
  input logic                        out_ready,
  input rvv_uop_pkg::uop_t [1:0]     out_uop,
  input rvv_vrf_pkg::uop_opn_t [1:0] out_opn
);

  int unsigned fail_count = 0;   // read by the testbench at the end

  reset_clears_output: assert property (@(posedge clk) rst |=> (out_valid == 2'b00) && in_ready[0])
    else begin
      $error("out_valid set or in_ready[0] low right after reset");
      fail_count++;
    end

  slot1_needs_slot0: assert property (@(posedge clk) disable iff (rst) out_valid[1] |-> out_valid[0])
    else begin
      $error("out_valid[1] set without out_valid[0]");
      fail_count++;
    end

  // a stalled pair must not change under the consumer
  stall_holds_output: assert property (@(posedge clk) disable iff (rst)
    ((|out_valid) && !out_ready) |=> $stable(out_valid) && $stable(out_uop) && $stable(out_opn))
    else begin
      $error("held output changed while out_ready was low");
      fail_count++;
    end

endmodule

bind rvv_dispatch_top rvv_dispatch_assertions u_dispatch_assertions (
  .clk       (clk),
  .rst       (rst),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_uop   (out_uop),
  .out_opn   (out_opn)
);

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  localparam realtime HALF_PERIOD = 4ns;   // 8 ns clock

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

/* source/rvv_dispatch_top.sv */
`timescale 1ns/1ps

module rvv_dispatch_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [1:0]                  in_valid,
  input  rvv_uop_pkg::uop_t [1:0]     in_uop,
  input  rvv_vrf_pkg::vrf_wr_t        vrf_wr,
  input  logic                        out_ready,
  output logic [1:0]                  in_ready,
  output logic [1:0]                  out_valid,
  output rvv_uop_pkg::uop_t [1:0]     out_uop,
  output rvv_vrf_pkg::uop_opn_t [1:0] out_opn
);

  rvv_vrf_pkg::vrf_rd_req_t [rvv_vrf_pkg::NUM_RD_PORT-1:0]   rd_req;
  rvv_uop_pkg::opn_plan_t [1:0]                              plan;
  rvv_uop_pkg::opn_plan_t [1:0]                              held_plan;
  logic                                                      slot1_fits;
  logic                                                      load;
  logic [rvv_vrf_pkg::NUM_RD_PORT-1:0][rvv_vrf_pkg::VLEN-1:0] rd_data;
  logic [rvv_vrf_pkg::VLEN-1:0]                              v0_mask;

  rvv_read_alloc u_read_alloc (
    .in_valid   (in_valid),
    .in_uop     (in_uop),
    .rd_req     (rd_req),
    .plan       (plan),
    .slot1_fits (slot1_fits)
  );

  rvv_vrf u_vrf (
    .clk     (clk),
    .rst     (rst),
    .vrf_wr  (vrf_wr),
    .rd_en   (load),
    .rd_req  (rd_req),
    .rd_data (rd_data),
    .v0_mask (v0_mask)
  );

  rvv_uop_stage u_uop_stage (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_uop     (in_uop),
    .plan       (plan),
    .slot1_fits (slot1_fits),
    .out_ready  (out_ready),
    .in_ready   (in_ready),
    .load       (load),
    .out_valid  (out_valid),
    .held_uop   (out_uop),
    .held_plan  (held_plan)
  );

  rvv_dispatch_operand u_dispatch_operand (
    .held_plan (held_plan),
    .rd_data   (rd_data),
    .v0_mask   (v0_mask),
    .out_opn   (out_opn)
  );

endmodule

/* source/rvv_dispatch_operand.sv */
`timescale 1ns/1ps

module rvv_dispatch_operand (
  input  rvv_uop_pkg::opn_plan_t [1:0]                               held_plan,
  input  logic [rvv_vrf_pkg::NUM_RD_PORT-1:0][rvv_vrf_pkg::VLEN-1:0] rd_data,
  input  logic [rvv_vrf_pkg::VLEN-1:0]                               v0_mask,
  output rvv_vrf_pkg::uop_opn_t [1:0]                                out_opn
);

  // planned port, or zero when the operand is not read
  function automatic logic [rvv_vrf_pkg::VLEN-1:0] pick_port(
    rvv_uop_pkg::opn_sel_t                                      sel,
    logic [rvv_vrf_pkg::NUM_RD_PORT-1:0][rvv_vrf_pkg::VLEN-1:0] data
  );
    if (sel.used) begin
      return data[sel.port];
    end
    return '0;
  endfunction

  // ***********************************************************
  // operand routing, no class decode needed
  // ***********************************************************
  always_comb begin
    for (int u = 0; u < 2; u++) begin
      out_opn[u].v0  = v0_mask;   // shared by both slots
      out_opn[u].vs1 = pick_port(held_plan[u].vs1, rd_data);
      out_opn[u].vs2 = pick_port(held_plan[u].vs2, rd_data);
      out_opn[u].vd  = pick_port(held_plan[u].vd, rd_data);
    end
  end

endmodule

/* source/rvv_uop_stage.sv */
`timescale 1ns/1ps

module rvv_uop_stage (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [1:0]                   in_valid,
  input  rvv_uop_pkg::uop_t [1:0]      in_uop,
  input  rvv_uop_pkg::opn_plan_t [1:0] plan,
  input  logic                         slot1_fits,
  input  logic                         out_ready,
  output logic [1:0]                   in_ready,
  output logic                         load,
  output logic [1:0]                   out_valid,
  output rvv_uop_pkg::uop_t [1:0]      held_uop,
  output rvv_uop_pkg::opn_plan_t [1:0] held_plan
);

  logic       full;
  logic [1:0] accept;

  assign full = |out_valid;
  assign load = ~full | out_ready;   // empty, or pair leaving now

  assign in_ready[0] = load;
  assign in_ready[1] = load & slot1_fits;

  assign accept = in_valid & in_ready;

  // ***********************************************************
  // control
  // ***********************************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= '0;
    end else if (load) begin
      out_valid <= accept;
    end
  end

  // payload, aligned with vrf read registers
  always_ff @(posedge clk) begin
    if (load) begin
      held_uop  <= in_uop;
      held_plan <= plan;
    end
  end

endmodule

/* source/rvv_vrf.sv */
`timescale 1ns/1ps

module rvv_vrf (
  input  logic                                                    clk,
  input  logic                                                    rst,
  input  rvv_vrf_pkg::vrf_wr_t                                    vrf_wr,
  input  logic                                                    rd_en,
  input  rvv_vrf_pkg::vrf_rd_req_t [rvv_vrf_pkg::NUM_RD_PORT-1:0] rd_req,
  output logic [rvv_vrf_pkg::NUM_RD_PORT-1:0][rvv_vrf_pkg::VLEN-1:0] rd_data,
  output logic [rvv_vrf_pkg::VLEN-1:0]                            v0_mask
);

  logic [rvv_vrf_pkg::VLEN-1:0] vreg [rvv_vrf_pkg::NUM_VREG];

  // ***********************************************************
  // write port
  // ***********************************************************
  always_ff @(posedge clk) begin
    if (vrf_wr.valid) begin
      vreg[vrf_wr.index] <= vrf_wr.data;
    end
  end

  // ***********************************************************
  // registered reads, sees array before this edge's write
  // ***********************************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_data <= '0;
      v0_mask <= '0;
    end else if (rd_en) begin
      for (int p = 0; p < rvv_vrf_pkg::NUM_RD_PORT; p++) begin
        if (rd_req[p].en) begin
          rd_data[p] <= vreg[rd_req[p].index];
        end else begin
          rd_data[p] <= '0;   // idle port
        end
      end
      v0_mask <= vreg[0];     // mask always from v0
    end
  end

endmodule

/* source/rvv_read_alloc.sv */
`timescale 1ns/1ps

module rvv_read_alloc (
  input  logic [1:0]                                              in_valid,
  input  rvv_uop_pkg::uop_t [1:0]                                 in_uop,
  output rvv_vrf_pkg::vrf_rd_req_t [rvv_vrf_pkg::NUM_RD_PORT-1:0] rd_req,
  output rvv_uop_pkg::opn_plan_t [1:0]                            plan,
  output logic                                                    slot1_fits
);

  logic [1:0][2:0] reads;     // {vd, vs2, vs1} per uop
  logic [1:0][2:0] rd_cnt;
  logic [2:0]      rd_total;
  logic [1:0]      grant;     // uop may claim its ports
  logic [2:0]      next_port;

  always_comb begin
    for (int u = 0; u < 2; u++) begin
      reads[u]  = rvv_uop_pkg::class_reads(in_uop[u].uop_class);
      rd_cnt[u] = {2'b0, reads[u][0]} + {2'b0, reads[u][1]} + {2'b0, reads[u][2]};
    end
  end

  assign rd_total   = rd_cnt[0] + rd_cnt[1];
  assign slot1_fits = rd_total <= 3'd4;   // from classes only, not valid
  assign grant      = {in_valid[1] & slot1_fits, in_valid[0]};

  // ***********************************************************
  // ports in order vs2, vs1, vd, uop 0 first
  // ***********************************************************
  always_comb begin
    next_port = '0;
    rd_req    = '0;
    plan      = '0;
    for (int u = 0; u < 2; u++) begin
      if (reads[u][1]) begin
        plan[u].vs2.used = 1'b1;
        plan[u].vs2.port = next_port[1:0];
        if (grant[u]) begin
          rd_req[next_port[1:0]].en    = 1'b1;
          rd_req[next_port[1:0]].index = in_uop[u].vs2_index;
        end
        next_port = next_port + 3'd1;
      end
      if (reads[u][0]) begin
        plan[u].vs1.used = 1'b1;
        plan[u].vs1.port = next_port[1:0];
        if (grant[u]) begin
          rd_req[next_port[1:0]].en    = 1'b1;
          rd_req[next_port[1:0]].index = in_uop[u].vs1_index;
        end
        next_port = next_port + 3'd1;
      end
      if (reads[u][2]) begin
        plan[u].vd.used = 1'b1;
        plan[u].vd.port = next_port[1:0];
        if (grant[u]) begin
          rd_req[next_port[1:0]].en    = 1'b1;
          rd_req[next_port[1:0]].index = in_uop[u].vd_index;
        end
        next_port = next_port + 3'd1;
      end
    end
  end

endmodule

/* source/rvv_vrf_pkg.sv */
package rvv_vrf_pkg;

  // ***********************************************************
  // register file sizes
  // ***********************************************************
  localparam int VLEN        = 64;
  localparam int NUM_VREG    = 32;
  localparam int NUM_RD_PORT = 4;
  localparam int VREG_IDX_W  = $clog2(NUM_VREG);

  typedef struct packed {
    logic                  en;
    logic [VREG_IDX_W-1:0] index;
  } vrf_rd_req_t;

  typedef struct packed {
    logic                  valid;
    logic [VREG_IDX_W-1:0] index;
    logic [VLEN-1:0]       data;
  } vrf_wr_t;

  // operands of one uop as they leave dispatch
  typedef struct packed {
    logic [VLEN-1:0] v0;
    logic [VLEN-1:0] vs1;
    logic [VLEN-1:0] vs2;
    logic [VLEN-1:0] vd;
  } uop_opn_t;

endpackage

/* source/rvv_uop_pkg.sv */
package rvv_uop_pkg;

  // ***********************************************************
  // uop class, letters in the order vd, vs2, vs1
  // ***********************************************************
  typedef enum logic [2:0] {
    XXX,
    XXV,
    XVX,
    VXX,
    XVV,
    VVX,
    VVV
  } uop_class_e;

  typedef enum logic [3:0] {
    VADD,
    VSUB,
    VAND,
    VOR,
    VMACC,
    VMV
  } vop_e;

  typedef struct packed {
    uop_class_e uop_class;
    vop_e       vop;        // not decoded here
    logic [4:0] vd_index;
    logic [4:0] vs2_index;
    logic [4:0] vs1_index;
    logic [3:0] uop_id;
  } uop_t;

  // one operand: read port and whether it is read at all
  typedef struct packed {
    logic       used;
    logic [1:0] port;
  } opn_sel_t;

  typedef struct packed {
    opn_sel_t vs1;
    opn_sel_t vs2;
    opn_sel_t vd;
  } opn_plan_t;

  // returns {vd, vs2, vs1} read flags
  function automatic logic [2:0] class_reads(uop_class_e uop_class);
    case (uop_class)
      XXV:     return 3'b001;
      XVX:     return 3'b010;
      VXX:     return 3'b100;
      XVV:     return 3'b011;
      VVX:     return 3'b110;
      VVV:     return 3'b111;
      default: return 3'b000;
    endcase
  endfunction

endpackage
